// ==== hw/mipsPkg.sv ====
package mipsPkg;

    localparam int dataWidth     = 32;
    localparam int regAddrWidth  = 5;
    localparam int memDepth      = 256;
    localparam int memIndexWidth = $clog2(memDepth);

    // Primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opOri   = 6'h0d;

    // R-type funct field
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    typedef logic [dataWidth-1:0]    wordT;
    typedef logic [regAddrWidth-1:0] regAddrT;

    typedef enum logic [2:0] {
        AluAnd,
        AluOr,
        AluAdd,
        AluSub,
        AluSlt
    } aluOpT;

    typedef struct packed {
        logic  regDst;    // Destination is rd, else rt
        logic  aluSrc;    // Immediate on operand B
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  regWrite;
        logic  zeroExt;   // ori only
        aluOpT aluOp;
    } ctrlT;

    typedef struct packed {
        wordT pcPlus4;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    rsData;
        wordT    rtData;
        wordT    imm;
        regAddrT rs;
        regAddrT rt;
        regAddrT rd;
    } idExT;

    typedef struct packed {
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    regWrite;
        wordT    aluResult;
        wordT    storeData;
        regAddrT rd;        // Already resolved destination
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        logic    memToReg;
        wordT    aluResult;
        wordT    loadData;
        regAddrT rd;
    } memWbT;

endpackage

// ==== hw/fetchStage.sv ====
module fetchStage (
    input  logic          clk,
    input  logic          reset,
    input  logic          stall,
    input  logic          branchTaken,
    input  mipsPkg::wordT branchTarget,
    output mipsPkg::ifIdT ifId
);
    import mipsPkg::*;

    wordT pc;
    wordT pcPlus4;
    wordT instr;
    wordT instrMem [memDepth];

    initial begin
        $readmemh("program.mem", instrMem);
    end

    assign pcPlus4 = pc + wordT'(4);
    assign instr   = instrMem[pc[memIndexWidth+1:2]];   // Word addressed

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= '0;
        end else if (branchTaken) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    // A taken branch squashes the instruction fetched behind it
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifId <= '0;
        end else if (branchTaken) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId.pcPlus4 <= pcPlus4;
            ifId.instr   <= instr;
        end
    end

    // Decode only resolves a branch once its operands are settled
    assert property (@(posedge clk) disable iff (reset) !(stall && branchTaken))
        else $error("stall and branchTaken high together");

endmodule

// ==== hw/decodeStage.sv ====
module decodeStage (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::ifIdT    ifId,
    input  logic             wbEnable,
    input  mipsPkg::regAddrT wbReg,
    input  mipsPkg::wordT    wbData,
    input  logic             exMemRegWrite,
    input  mipsPkg::regAddrT exMemRd,
    input  logic             idExMemRead,
    input  mipsPkg::regAddrT idExRt,
    output mipsPkg::idExT    idEx,
    output logic             stall,
    output logic             branchTaken,
    output mipsPkg::wordT    branchTarget
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddrT    rs;
    regAddrT    rt;
    regAddrT    rd;
    wordT       signExt;
    wordT       immExt;
    wordT       rsData;
    wordT       rtData;
    ctrlT       ctrl;
    logic       isBeq;
    logic       usesRt;
    logic       loadUse;
    regAddrT    idExDest;
    logic       branchHazard;
    wordT       regs [2**regAddrWidth];

    assign opcode = ifId.instr[31:26];
    assign rs     = ifId.instr[25:21];
    assign rt     = ifId.instr[20:16];
    assign rd     = ifId.instr[15:11];
    assign funct  = ifId.instr[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            opRtype: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    fnAdd:   ctrl.aluOp = AluAdd;
                    fnSub:   ctrl.aluOp = AluSub;
                    fnAnd:   ctrl.aluOp = AluAnd;
                    fnOr:    ctrl.aluOp = AluOr;
                    fnSlt:   ctrl.aluOp = AluSlt;
                    default: ctrl.regWrite = 1'b0;   // Unknown funct acts as a nop
                endcase
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = AluAdd;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = AluAdd;
            end
            opOri: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.zeroExt  = 1'b1;
                ctrl.aluOp    = AluOr;
            end
            default: ;   // beq needs no EX work
        endcase
    end

    assign isBeq   = (opcode == opBeq);
    assign usesRt  = (opcode == opRtype) || (opcode == opSw) || isBeq;
    assign signExt = {{(dataWidth-16){ifId.instr[15]}}, ifId.instr[15:0]};
    assign immExt  = ctrl.zeroExt ? {{(dataWidth-16){1'b0}}, ifId.instr[15:0]} : signExt;

    // Register file, writeback visible in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) regs[i] <= '0;
        end else if (wbEnable) begin
            regs[wbReg] <= wbData;
        end
    end

    assign rsData = (wbEnable && wbReg == rs) ? wbData : regs[rs];
    assign rtData = (wbEnable && wbReg == rt) ? wbData : regs[rt];

    assign loadUse = idExMemRead && idExRt != '0 &&
                     (idExRt == rs || (usesRt && idExRt == rt));

    // beq compares in ID, so it waits out any writer still in EX or MEM
    assign idExDest     = idEx.ctrl.regDst ? idEx.rd : idEx.rt;
    assign branchHazard = isBeq &&
        ((idEx.ctrl.regWrite && idExDest != '0 && (idExDest == rs || idExDest == rt)) ||
         (exMemRegWrite && exMemRd != '0 && (exMemRd == rs || exMemRd == rt)));

    assign stall        = loadUse || branchHazard;
    assign branchTaken  = isBeq && !stall && (rsData == rtData);
    assign branchTarget = ifId.pcPlus4 + {signExt[dataWidth-3:0], 2'b00};

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idEx <= '0;
        end else if (stall) begin
            idEx <= '0;   // Bubble
        end else begin
            idEx.ctrl   <= ctrl;
            idEx.rsData <= rsData;
            idEx.rtData <= rtData;
            idEx.imm    <= immExt;
            idEx.rs     <= rs;
            idEx.rt     <= rt;
            idEx.rd     <= rd;
        end
    end

    assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
        else $error("register 0 was written");

endmodule

// ==== hw/executeStage.sv ====
module executeStage (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::idExT    idEx,
    input  logic             wbEnable,
    input  mipsPkg::regAddrT wbReg,
    input  mipsPkg::wordT    wbData,
    output mipsPkg::exMemT   exMem,
    output logic             idExMemRead,
    output mipsPkg::regAddrT idExRt
);
    import mipsPkg::*;

    wordT    opA;
    wordT    rtFwd;
    wordT    opB;
    wordT    aluResult;
    regAddrT dest;

    // Newest producer first, $0 is never forwarded
    function automatic wordT forwardOperand(regAddrT src, wordT regVal);
        if (exMem.regWrite && exMem.rd != '0 && exMem.rd == src) begin
            return exMem.aluResult;
        end
        if (wbEnable && wbReg == src) begin
            return wbData;
        end
        return regVal;
    endfunction

    always_comb begin
        opA   = forwardOperand(idEx.rs, idEx.rsData);
        rtFwd = forwardOperand(idEx.rt, idEx.rtData);
    end

    assign opB = idEx.ctrl.aluSrc ? idEx.imm : rtFwd;

    always_comb begin
        case (idEx.ctrl.aluOp)
            AluAnd:  aluResult = opA & opB;
            AluOr:   aluResult = opA | opB;
            AluAdd:  aluResult = opA + opB;
            AluSub:  aluResult = opA - opB;
            AluSlt:  aluResult = ($signed(opA) < $signed(opB)) ? wordT'(1) : '0;
            default: aluResult = '0;
        endcase
    end

    assign dest = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exMem <= '0;
        end else begin
            exMem.memRead   <= idEx.ctrl.memRead;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.memToReg  <= idEx.ctrl.memToReg;
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.aluResult <= aluResult;
            exMem.storeData <= rtFwd;   // sw data may itself be forwarded
            exMem.rd        <= dest;
        end
    end

    // Seen by decode for load-use detection
    assign idExMemRead = idEx.ctrl.memRead;
    assign idExRt      = idEx.rt;

    assert property (@(posedge clk) disable iff (reset) !(exMem.memRead && exMem.memWrite))
        else $error("load and store active together in EX/MEM");

endmodule

// ==== hw/memoryStage.sv ====
module memoryStage (
    input  logic            clk,
    input  logic            reset,
    input  mipsPkg::exMemT  exMem,
    output mipsPkg::memWbT  memWb
);
    import mipsPkg::*;

    logic [memIndexWidth-1:0] wordIndex;
    wordT                     loadData;
    wordT                     dataMem [memDepth];

    assign wordIndex = exMem.aluResult[memIndexWidth+1:2];

    always_ff @(posedge clk) begin
        if (exMem.memWrite) begin
            dataMem[wordIndex] <= exMem.storeData;
        end
    end

    assign loadData = exMem.memRead ? dataMem[wordIndex] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            memWb <= '0;
        end else begin
            memWb.regWrite  <= exMem.regWrite;
            memWb.memToReg  <= exMem.memToReg;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= loadData;
            memWb.rd        <= exMem.rd;
        end
    end

    // Word accesses only
    assert property (@(posedge clk) disable iff (reset)
        (exMem.memRead || exMem.memWrite) |-> exMem.aluResult[1:0] == 2'b00)
        else $error("unaligned data access at %h", exMem.aluResult);

endmodule

// ==== hw/mipsPipeline.sv ====
module mipsPipeline (
    input  logic             clk,
    input  logic             reset,
    output logic             retireValid,
    output mipsPkg::regAddrT retireReg,
    output mipsPkg::wordT    retireData,
    output logic             storeValid,
    output mipsPkg::wordT    storeAddr,
    output mipsPkg::wordT    storeData
);
    import mipsPkg::*;

    logic    stall;
    logic    branchTaken;
    wordT    branchTarget;
    ifIdT    ifId;
    idExT    idEx;
    exMemT   exMem;
    memWbT   memWb;
    logic    idExMemRead;
    regAddrT idExRt;
    logic    wbEnable;
    regAddrT wbReg;
    wordT    wbData;

    assign wbEnable = memWb.regWrite && memWb.rd != '0;   // Writes to $0 dropped here
    assign wbReg    = memWb.rd;
    assign wbData   = memWb.memToReg ? memWb.loadData : memWb.aluResult;

    fetchStage fetchUnit (.clk, .reset, .stall, .branchTaken, .branchTarget, .ifId);

    decodeStage decodeUnit (
        .clk, .reset, .ifId, .wbEnable, .wbReg, .wbData,
        .exMemRegWrite(exMem.regWrite), .exMemRd(exMem.rd),
        .idExMemRead, .idExRt, .idEx, .stall, .branchTaken, .branchTarget
    );

    executeStage executeUnit (
        .clk, .reset, .idEx, .wbEnable, .wbReg, .wbData, .exMem, .idExMemRead, .idExRt
    );

    memoryStage memoryUnit (.clk, .reset, .exMem, .memWb);

    assign retireValid = wbEnable;
    assign retireReg   = wbReg;
    assign retireData  = wbData;
    assign storeValid  = exMem.memWrite;
    assign storeAddr   = exMem.aluResult;
    assign storeData   = exMem.storeData;

endmodule

// ==== sim/expectedRetire.svh ====
`ifndef EXPECTED_RETIRE_SVH
`define EXPECTED_RETIRE_SVH

// Retire entries are {destination, value} in program order
localparam int retireTotal = 14;
localparam logic [36:0] retireSeq [retireTotal] = '{
    {5'd1,  32'h0000_000c},
    {5'd2,  32'h0000_000a},
    {5'd3,  32'h0000_0016},   // 12 + 10
    {5'd4,  32'h0000_000a},
    {5'd5,  32'h0000_0002},
    {5'd6,  32'h0000_001e},
    {5'd7,  32'h0000_0001},
    {5'd8,  32'h0000_001e},   // Loaded back from address 8
    {5'd9,  32'h0000_001f},
    {5'd10, 32'h0000_000c},   // $0 reads as zero
    {5'd12, 32'h0000_00ff},   // $11 never shows up
    {5'd13, 32'h0000_00e1},
    {5'd14, 32'hffff_ff1f},
    {5'd15, 32'h0000_0001}
};

// Store entries are {address, data}
localparam int storeTotal = 1;
localparam logic [63:0] storeSeq [storeTotal] = '{
    {32'h0000_0008, 32'h0000_001e}
};

function automatic string retireLabel(int idx);
    case (idx)
        0:       return "ori $1 constant";
        1:       return "ori $2 constant";
        2:       return "add fwd EX/MEM and MEM/WB";
        3:       return "sub fwd EX/MEM";
        4:       return "and";
        5:       return "or";
        6:       return "slt";
        7:       return "lw after sw";
        8:       return "add after load-use stall";
        9:       return "add reads $0";
        10:      return "ori after taken beq";
        11:      return "sub fwd after ori";
        12:      return "sub negative";
        13:      return "slt negative";
        default: return "retire out of range";
    endcase
endfunction

function automatic string storeLabel(int idx);
    return (idx == 0) ? "sw $6 to 8" : "store out of range";
endfunction

`endif

// ==== sim/tbMips.sv ====
module tbMips;
    import mipsPkg::*;

    `include "expectedRetire.svh"

    localparam int resetCycles   = 5;
    localparam int driveDelay    = 2;
    localparam int programLength = 20;
    localparam int worstCpi      = 3;
    localparam int marginCycles  = 335;
    localparam int timeoutCycles = resetCycles + programLength * worstCpi + marginCycles;
    localparam int drainCycles   = 10;

    logic    clk = 1'b0;
    logic    reset;
    logic    retireValid;
    regAddrT retireReg;
    wordT    retireData;
    logic    storeValid;
    wordT    storeAddr;
    wordT    storeData;

    int retireIdx     = 0;
    int storeIdx      = 0;
    int cycleCount    = 0;
    int mismatchCount = 0;
    int otherErrors   = 0;

    mipsPipeline UUT (
        .clk, .reset, .retireValid, .retireReg, .retireData,
        .storeValid, .storeAddr, .storeData
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    // Position in the expected sequences
    always @(posedge clk) begin
        if (!reset && retireValid) begin
            retireIdx <= retireIdx + 1;
        end
        if (!reset && storeValid) begin
            storeIdx <= storeIdx + 1;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        retireValid && retireIdx < retireTotal |-> retireReg == retireSeq[retireIdx][36:32])
        else begin
            mismatchCount++;
            $display("MISMATCH %s reg: expected $%0d, actual $%0d",
                     retireLabel($sampled(retireIdx)),
                     retireSeq[$sampled(retireIdx)][36:32], $sampled(retireReg));
        end

    assert property (@(posedge clk) disable iff (reset)
        retireValid && retireIdx < retireTotal |-> retireData == retireSeq[retireIdx][31:0])
        else begin
            mismatchCount++;
            $display("MISMATCH %s data: expected %h, actual %h",
                     retireLabel($sampled(retireIdx)),
                     retireSeq[$sampled(retireIdx)][31:0], $sampled(retireData));
        end

    assert property (@(posedge clk) disable iff (reset)
        storeValid && storeIdx < storeTotal |-> storeAddr == storeSeq[storeIdx][63:32])
        else begin
            mismatchCount++;
            $display("MISMATCH %s addr: expected %h, actual %h",
                     storeLabel($sampled(storeIdx)),
                     storeSeq[$sampled(storeIdx)][63:32], $sampled(storeAddr));
        end

    assert property (@(posedge clk) disable iff (reset)
        storeValid && storeIdx < storeTotal |-> storeData == storeSeq[storeIdx][31:0])
        else begin
            mismatchCount++;
            $display("MISMATCH %s data: expected %h, actual %h",
                     storeLabel($sampled(storeIdx)),
                     storeSeq[$sampled(storeIdx)][31:0], $sampled(storeData));
        end

    // Nothing may retire or store past the end of the lists
    assert property (@(posedge clk) disable iff (reset) retireValid |-> retireIdx < retireTotal)
        else begin
            otherErrors++;
            $display("Unexpected retire to $%0d after the expected sequence",
                     $sampled(retireReg));
        end

    assert property (@(posedge clk) disable iff (reset) storeValid |-> storeIdx < storeTotal)
        else begin
            otherErrors++;
            $display("Unexpected store to %h after the expected sequence", $sampled(storeAddr));
        end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #driveDelay reset = 1'b0;

        @(negedge clk);
        while (!(retireIdx == retireTotal && storeIdx == storeTotal) &&
               cycleCount < timeoutCycles) begin
            @(negedge clk);
        end

        if (retireIdx == retireTotal && storeIdx == storeTotal) begin
            repeat (drainCycles) @(negedge clk);   // Room for a stray retire to show up
        end else begin
            otherErrors++;
            $display("Timeout after %0d cycles before the program finished", cycleCount);
        end

        if (retireIdx < retireTotal) begin
            otherErrors++;
            $display("Only %0d of %0d expected retires appeared", retireIdx, retireTotal);
        end
        if (storeIdx < storeTotal) begin
            otherErrors++;
            $display("Only %0d of %0d expected stores appeared", storeIdx, storeTotal);
        end

        $display("Summary: %0d mismatches, %0d other errors", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+sim
hw/mipsPkg.sv
hw/fetchStage.sv
hw/decodeStage.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/mipsPipeline.sv
sim/tbMips.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator, run it, then check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --assert --top-module tbMips -f verilog.f -o tbMips \
    && ./obj_dir/tbMips 2>&1 | tee "$LOG" \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "All checks passed" "$LOG" && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== program.mem ====
// One 32-bit instruction word per line in hex, starting at address 0
// The assembly of each word follows it as a comment
3401000c  // ori  $1, $0, 0x000c
3402000a  // ori  $2, $0, 0x000a
00221820  // add  $3, $1, $2     $2 from EX/MEM, $1 from MEM/WB
00612022  // sub  $4, $3, $1
00642824  // and  $5, $3, $4
00643025  // or   $6, $3, $4
0083382a  // slt  $7, $4, $3
ac060008  // sw   $6, 8($0)
8c080008  // lw   $8, 8($0)
01074820  // add  $9, $8, $7     load-use stall
11260001  // beq  $9, $6, +1     not taken, waits on $9
00220020  // add  $0, $1, $2     discarded
00015020  // add  $10, $0, $1
11410001  // beq  $10, $1, +1    taken, waits on $10
340bdead  // ori  $11, $0, 0xdead   skipped
340c00ff  // ori  $12, $0, 0x00ff
01866822  // sub  $13, $12, $6
00cc7022  // sub  $14, $6, $12   negative
01c0782a  // slt  $15, $14, $0
1000ffff  // beq  $0, $0, -1     spin here
